/* source/clint_settings.svh */
`ifndef CLINT_SETTINGS_SVH
`define CLINT_SETTINGS_SVH

// register map, low 16 address bits as decoded by the timer block
`define CLINT_MTIMECMP_OFFSET 16'h4000
`define CLINT_MTIME_OFFSET    16'hbff8

// compare value loaded at reset
// the first timer pulse follows once mtime has counted up to it
`define CLINT_MTIMECMP_RESET  64'd4

// AXI response codes
`define CLINT_RESP_OKAY       2'b00
`define CLINT_RESP_SLVERR     2'b10

`endif

/* source/clint_pkg.sv */
package clint_pkg;

    // full bus address, only the low bits are decoded
    typedef logic [63:0] addr_t;

    // one register or one data beat
    typedef logic [63:0] data_t;

    // one strobe bit per data byte
    typedef logic [7:0] strb_t;

    // register offset inside the CLINT window
    typedef logic [15:0] offset_t;

    // bresp / rresp encoding
    typedef logic [1:0] resp_t;

    // write channel, WR_RESP covers the accept cycle and the pending B beat
    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_t;

    // read channel, RD_DATA lasts until the R beat is taken
    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_t;

endpackage

/* source/clint_axi_slave.sv */
`include "clint_settings.svh"

module clint_axi_slave (
    input  logic              clk,
    input  logic              rst_n,

    // write address and data channels
    input  clint_pkg::addr_t  axi_awaddr,
    input  logic              axi_awvalid,
    output logic              axi_awready,
    input  clint_pkg::data_t  axi_wdata,
    input  clint_pkg::strb_t  axi_wstrb,
    input  logic              axi_wvalid,
    output logic              axi_wready,

    // write response channel
    output clint_pkg::resp_t  axi_bresp,
    output logic              axi_bvalid,
    input  logic              axi_bready,

    // read address and data channels
    input  clint_pkg::addr_t  axi_araddr,
    input  logic              axi_arvalid,
    output logic              axi_arready,
    output clint_pkg::data_t  axi_rdata,
    output clint_pkg::resp_t  axi_rresp,
    output logic              axi_rvalid,
    input  logic              axi_rready,

    // register access towards the timer
    output logic              wr_en,
    output clint_pkg::offset_t wr_offset,
    output clint_pkg::data_t  wr_data,
    output clint_pkg::strb_t  wr_strb,
    output logic              rd_en,
    output clint_pkg::offset_t rd_offset,
    input  clint_pkg::data_t  rd_data,
    input  logic              wr_hit,
    input  logic              rd_hit
);

    clint_pkg::wr_state_t wr_state;
    clint_pkg::rd_state_t rd_state;

    // shared ready for the address and data channels of a write
    logic                 wr_accept;
    logic                 wr_start;
    logic                 rd_start;

    // a write is only taken when both halves are present and no B beat is owed
    assign wr_start = (wr_state == clint_pkg::WR_IDLE) && axi_awvalid && axi_wvalid;

    // handshake cycle of both write channels
    assign wr_en = wr_accept && axi_awvalid && axi_wvalid;

    assign axi_awready = wr_accept;
    assign axi_wready  = wr_accept;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_state   <= clint_pkg::WR_IDLE;
            wr_accept  <= 1'b0;
            axi_bvalid <= 1'b0;
        end
        else
        begin
            // ready is high for exactly one cycle per accepted write
            wr_accept <= wr_start;

            case (wr_state)
                clint_pkg::WR_IDLE:
                begin
                    if (wr_start)
                    begin
                        wr_state <= clint_pkg::WR_RESP;
                    end
                end
                clint_pkg::WR_RESP:
                begin
                    if (axi_bvalid && axi_bready)
                    begin
                        wr_state <= clint_pkg::WR_IDLE;
                    end
                end
                default:
                begin
                    wr_state <= clint_pkg::WR_IDLE;
                end
            endcase

            if (wr_en)
            begin
                axi_bvalid <= 1'b1;
            end
            else if (axi_bvalid && axi_bready)
            begin
                axi_bvalid <= 1'b0;
            end
        end
    end

    // write payload, captured while the master holds it
    always_ff @(posedge clk)
    begin
        if (wr_start)
        begin
            wr_offset <= axi_awaddr[15:0];
            wr_data   <= axi_wdata;
            wr_strb   <= axi_wstrb;
        end
        if (wr_en)
        begin
            axi_bresp <= wr_hit ? `CLINT_RESP_OKAY : `CLINT_RESP_SLVERR;
        end
    end

    assign rd_start = (rd_state == clint_pkg::RD_IDLE) && axi_arvalid;
    assign rd_en    = axi_arready && axi_arvalid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_state    <= clint_pkg::RD_IDLE;
            axi_arready <= 1'b0;
            axi_rvalid  <= 1'b0;
        end
        else
        begin
            axi_arready <= rd_start;

            case (rd_state)
                clint_pkg::RD_IDLE:
                begin
                    if (rd_start)
                    begin
                        rd_state <= clint_pkg::RD_DATA;
                    end
                end
                clint_pkg::RD_DATA:
                begin
                    if (axi_rvalid && axi_rready)
                    begin
                        rd_state <= clint_pkg::RD_IDLE;
                    end
                end
                default:
                begin
                    rd_state <= clint_pkg::RD_IDLE;
                end
            endcase

            if (rd_en)
            begin
                axi_rvalid <= 1'b1;
            end
            else if (axi_rvalid && axi_rready)
            begin
                axi_rvalid <= 1'b0;
            end
        end
    end

    // read offset and result, held until the R beat completes
    always_ff @(posedge clk)
    begin
        if (rd_start)
        begin
            rd_offset <= axi_araddr[15:0];
        end
        if (rd_en)
        begin
            // unmapped offsets return zero data
            axi_rdata <= rd_hit ? rd_data : '0;
            axi_rresp <= rd_hit ? `CLINT_RESP_OKAY : `CLINT_RESP_SLVERR;
        end
    end

endmodule

/* source/clint_timer.sv */
`include "clint_settings.svh"

module clint_timer (
    input  logic               clk,
    input  logic               rst_n,

    // register access from the bus front end
    input  logic               wr_en,
    input  clint_pkg::offset_t wr_offset,
    input  clint_pkg::data_t   wr_data,
    input  clint_pkg::strb_t   wr_strb,
    input  logic               rd_en,
    input  clint_pkg::offset_t rd_offset,
    output clint_pkg::data_t   rd_data,
    output logic               wr_hit,
    output logic               rd_hit,

    // one-cycle machine timer interrupt
    output logic               timer_irq
);

    clint_pkg::data_t mtime;
    clint_pkg::data_t mtimecmp;

    // offset decode
    logic             wr_mtime;
    logic             wr_mtimecmp;
    logic             rd_mtime;
    logic             rd_mtimecmp;

    // registered compare result and its previous value
    logic             pending;
    logic             pending_d;

    // bytes with a strobe take the new value, the rest keep the old one
    function automatic clint_pkg::data_t byte_merge(
        input clint_pkg::data_t cur,
        input clint_pkg::data_t upd,
        input clint_pkg::strb_t strb
    );
        clint_pkg::data_t result;
        result = cur;
        for (int i = 0; i < $bits(clint_pkg::strb_t); i++)
        begin
            if (strb[i])
            begin
                result[i*8 +: 8] = upd[i*8 +: 8];
            end
        end
        return result;
    endfunction

    assign wr_mtime    = (wr_offset == `CLINT_MTIME_OFFSET);
    assign wr_mtimecmp = (wr_offset == `CLINT_MTIMECMP_OFFSET);
    assign rd_mtime    = (rd_offset == `CLINT_MTIME_OFFSET);
    assign rd_mtimecmp = (rd_offset == `CLINT_MTIMECMP_OFFSET);

    // the slave picks OKAY or SLVERR from these
    assign wr_hit = wr_mtime || wr_mtimecmp;
    assign rd_hit = rd_mtime || rd_mtimecmp;

    // a written mtime skips the increment for that cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtime <= '0;
        end
        else if (wr_en && wr_mtime)
        begin
            mtime <= byte_merge(mtime, wr_data, wr_strb);
        end
        else
        begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtimecmp <= `CLINT_MTIMECMP_RESET;
        end
        else if (wr_en && wr_mtimecmp)
        begin
            mtimecmp <= byte_merge(mtimecmp, wr_data, wr_strb);
        end
    end

    // value before the read handshake edge, captured by the slave
    always_comb
    begin
        rd_data = '0;
        if (rd_en)
        begin
            if (rd_mtime)
            begin
                rd_data = mtime;
            end
            else if (rd_mtimecmp)
            begin
                rd_data = mtimecmp;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending   <= 1'b0;
            pending_d <= 1'b0;
        end
        else
        begin
            pending   <= (mtime >= mtimecmp);
            pending_d <= pending;
        end
    end

    // rising edge of pending gives a single pulse
    assign timer_irq = pending && !pending_d;

endmodule

/* source/clint.sv */
module clint (
    input  logic             clk,
    input  logic             rst_n,

    input  clint_pkg::addr_t axi_awaddr,
    input  logic             axi_awvalid,
    output logic             axi_awready,
    input  clint_pkg::data_t axi_wdata,
    input  clint_pkg::strb_t axi_wstrb,
    input  logic             axi_wvalid,
    output logic             axi_wready,
    output clint_pkg::resp_t axi_bresp,
    output logic             axi_bvalid,
    input  logic             axi_bready,

    input  clint_pkg::addr_t axi_araddr,
    input  logic             axi_arvalid,
    output logic             axi_arready,
    output clint_pkg::data_t axi_rdata,
    output clint_pkg::resp_t axi_rresp,
    output logic             axi_rvalid,
    input  logic             axi_rready,

    output logic             timer_irq
);

    // register access between the bus front end and the timer
    logic               wr_en;
    clint_pkg::offset_t wr_offset;
    clint_pkg::data_t   wr_data;
    clint_pkg::strb_t   wr_strb;
    logic               rd_en;
    clint_pkg::offset_t rd_offset;
    clint_pkg::data_t   rd_data;
    logic               wr_hit;
    logic               rd_hit;

    clint_axi_slave slave0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .axi_awaddr  (axi_awaddr),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_bresp   (axi_bresp),
        .axi_bvalid  (axi_bvalid),
        .axi_bready  (axi_bready),
        .axi_araddr  (axi_araddr),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_rdata   (axi_rdata),
        .axi_rresp   (axi_rresp),
        .axi_rvalid  (axi_rvalid),
        .axi_rready  (axi_rready),
        .wr_en       (wr_en),
        .wr_offset   (wr_offset),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .rd_en       (rd_en),
        .rd_offset   (rd_offset),
        .rd_data     (rd_data),
        .wr_hit      (wr_hit),
        .rd_hit      (rd_hit)
    );

    clint_timer timer0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_offset (wr_offset),
        .wr_data   (wr_data),
        .wr_strb   (wr_strb),
        .rd_en     (rd_en),
        .rd_offset (rd_offset),
        .rd_data   (rd_data),
        .wr_hit    (wr_hit),
        .rd_hit    (rd_hit),
        .timer_irq (timer_irq)
    );

endmodule

/* testbench/clint_properties.sv */
module clint_properties (
    input logic             clk,
    input logic             rst_n,
    input logic             axi_awvalid,
    input logic             axi_awready,
    input logic             axi_wvalid,
    input logic             axi_bvalid,
    input logic             axi_bready,
    input logic             axi_rvalid,
    input logic             axi_rready,
    input clint_pkg::data_t axi_rdata,
    input clint_pkg::resp_t axi_rresp,
    input logic             timer_irq
);
    timeunit 1ns;
    timeprecision 100ps;

    // response beats stay up until the master takes them
    bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        axi_bvalid && !axi_bready |=> axi_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        axi_rvalid && !axi_rready |=> axi_rvalid)
        else $error("rvalid dropped before rready");

    rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        axi_rvalid && !axi_rready |=> $stable(axi_rdata) && $stable(axi_rresp))
        else $error("read data changed under back-pressure");

    // a write is only accepted with both halves present
    awready_paired: assert property (@(posedge clk) disable iff (!rst_n)
        axi_awready |-> axi_awvalid && axi_wvalid)
        else $error("awready without awvalid and wvalid");

    irq_single: assert property (@(posedge clk) disable iff (!rst_n)
        timer_irq |=> !timer_irq)
        else $error("timer_irq high for two cycles");

endmodule

bind clint clint_properties props0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .axi_awvalid (axi_awvalid),
    .axi_awready (axi_awready),
    .axi_wvalid  (axi_wvalid),
    .axi_bvalid  (axi_bvalid),
    .axi_bready  (axi_bready),
    .axi_rvalid  (axi_rvalid),
    .axi_rready  (axi_rready),
    .axi_rdata   (axi_rdata),
    .axi_rresp   (axi_rresp),
    .timer_irq   (timer_irq)
);

/* testbench/clint_tb.sv */
`include "clint_settings.svh"

module clint_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 2;
    localparam int RESET_CYCLES = 5;
    // roughly ten times the few hundred cycles that the six tests take
    localparam int TIMEOUT_CYCLES = 3000;
    localparam logic [31:0] LFSR_SEED = 32'h7fa6_072b;
    localparam clint_pkg::offset_t UNMAPPED_OFFSET = 16'h0100;
    localparam clint_pkg::data_t MTIMECMP_AFTER_RESET = 64'd4;

    logic               clk = 1'b0;
    logic               rst_n;
    clint_pkg::addr_t   axi_awaddr;
    logic               axi_awvalid;
    logic               axi_awready;
    clint_pkg::data_t   axi_wdata;
    clint_pkg::strb_t   axi_wstrb;
    logic               axi_wvalid;
    logic               axi_wready;
    clint_pkg::resp_t   axi_bresp;
    logic               axi_bvalid;
    logic               axi_bready;
    clint_pkg::addr_t   axi_araddr;
    logic               axi_arvalid;
    logic               axi_arready;
    clint_pkg::data_t   axi_rdata;
    clint_pkg::resp_t   axi_rresp;
    logic               axi_rvalid;
    logic               axi_rready;
    logic               timer_irq;

    int                 cycle_count = 0;
    int                 irq_count = 0;
    logic [31:0]        lfsr_state;

    // the model's mtime equals base right after edge number model_mtime_edge
    clint_pkg::data_t   model_mtime_base;
    int                 model_mtime_edge;
    clint_pkg::data_t   model_mtimecmp;

    clint dut0 (.*);

    initial
    begin
        forever
        begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // rising edge count, pulse count and run limit
    always @(posedge clk)
    begin
        cycle_count++;
        if (timer_irq === 1'b1)
        begin
            irq_count++;
        end
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            stop_run($sformatf("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first failing check");
    endtask

    task automatic check_data(input string test, input clint_pkg::data_t exp,
                              input clint_pkg::data_t act);
        if (act !== exp)
        begin
            stop_run($sformatf("ERR %s expected %h actual %h", test, exp, act));
        end
    endtask

    task automatic check_resp(input string test, input clint_pkg::resp_t exp,
                              input clint_pkg::resp_t act);
        if (act !== exp)
        begin
            stop_run($sformatf("ERR %s expected resp %b actual resp %b", test, exp, act));
        end
    endtask

    task automatic check_bit(input string test, input logic exp, input logic act);
        if (act !== exp)
        begin
            stop_run($sformatf("ERR %s expected %b actual %b", test, exp, act));
        end
    endtask

    task automatic check_irq(input string test, input int exp, input int act);
        if (act != exp)
        begin
            stop_run($sformatf("ERR %s expected %0d pulses actual %0d", test, exp, act));
        end
    endtask

    // galois form with one output bit per step
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit)
        begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic clint_pkg::data_t take_bits(input int count);
        clint_pkg::data_t value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value = {value[62:0], lfsr_step()};
        end
        return value;
    endfunction

    function automatic clint_pkg::data_t merge_bytes(input clint_pkg::data_t cur,
                                                     input clint_pkg::data_t upd,
                                                     input clint_pkg::strb_t strb);
        clint_pkg::data_t mask;
        for (int b = 0; b < 8; b++)
        begin
            mask[b*8 +: 8] = {8{strb[b]}};
        end
        return (cur & ~mask) | (upd & mask);
    endfunction

    // value of mtime just before the given rising edge
    function automatic clint_pkg::data_t mtime_before(input int edge_no);
        return model_mtime_base + 64'(edge_no - model_mtime_edge - 1);
    endfunction

    task automatic idle_bus();
        axi_awaddr = '0;
        axi_awvalid = 1'b0;
        axi_wdata = '0;
        axi_wstrb = '0;
        axi_wvalid = 1'b0;
        axi_bready = 1'b0;
        axi_araddr = '0;
        axi_arvalid = 1'b0;
        axi_rready = 1'b0;
    endtask

    task automatic offer_write(input clint_pkg::offset_t offset, input clint_pkg::data_t data,
                               input clint_pkg::strb_t strb);
        axi_awaddr = {48'h0, offset};
        axi_awvalid = 1'b1;
        axi_wdata = data;
        axi_wstrb = strb;
        axi_wvalid = 1'b1;
    endtask

    // returns on the falling edge after the handshake edge
    task automatic finish_write_handshake(output int hs_edge);
        @(negedge clk);
        while (axi_awready !== 1'b1)
        begin
            @(negedge clk);
        end
        check_bit("write_handshake", 1'b1, axi_wready);
        hs_edge = cycle_count + 1;
        @(negedge clk);
        axi_awvalid = 1'b0;
        axi_wvalid = 1'b0;
        check_bit("write_handshake", 1'b0, axi_awready);
        check_bit("write_handshake", 1'b0, axi_wready);
    endtask

    task automatic collect_write_response(input int delay, output clint_pkg::resp_t resp);
        repeat (delay) @(negedge clk);
        if (axi_bvalid !== 1'b1)
        begin
            stop_run("bvalid was not raised after the write handshake");
        end
        resp = axi_bresp;
        axi_bready = 1'b1;
        @(negedge clk);
        axi_bready = 1'b0;
    endtask

    task automatic offer_read(input clint_pkg::offset_t offset);
        axi_araddr = {48'h0, offset};
        axi_arvalid = 1'b1;
    endtask

    task automatic finish_read_handshake(output int hs_edge);
        @(negedge clk);
        while (axi_arready !== 1'b1)
        begin
            @(negedge clk);
        end
        hs_edge = cycle_count + 1;
        @(negedge clk);
        axi_arvalid = 1'b0;
        check_bit("read_handshake", 1'b0, axi_arready);
    endtask

    task automatic collect_read_response(input int delay, output clint_pkg::data_t data,
                                         output clint_pkg::resp_t resp);
        repeat (delay) @(negedge clk);
        if (axi_rvalid !== 1'b1)
        begin
            stop_run("rvalid was not raised after the read handshake");
        end
        data = axi_rdata;
        resp = axi_rresp;
        axi_rready = 1'b1;
        @(negedge clk);
        axi_rready = 1'b0;
    endtask

    task automatic axi_write(input clint_pkg::offset_t offset, input clint_pkg::data_t data,
                             input clint_pkg::strb_t strb, output clint_pkg::resp_t resp,
                             output int hs_edge);
        int delay;
        delay = int'(take_bits(2));
        offer_write(offset, data, strb);
        finish_write_handshake(hs_edge);
        collect_write_response(delay, resp);
    endtask

    task automatic axi_read(input clint_pkg::offset_t offset, output clint_pkg::data_t data,
                            output clint_pkg::resp_t resp, output int hs_edge);
        int delay;
        delay = int'(take_bits(2));
        offer_read(offset);
        finish_read_handshake(hs_edge);
        collect_read_response(delay, data, resp);
    endtask

    // mapped write that expects OKAY and updates the model
    task automatic write_reg(input string test, input clint_pkg::offset_t offset,
                             input clint_pkg::data_t data, input clint_pkg::strb_t strb);
        clint_pkg::resp_t resp;
        int hs_edge;
        axi_write(offset, data, strb, resp, hs_edge);
        check_resp(test, `CLINT_RESP_OKAY, resp);
        if (offset == `CLINT_MTIME_OFFSET)
        begin
            model_mtime_base = merge_bytes(mtime_before(hs_edge), data, strb);
            model_mtime_edge = hs_edge;
        end
        else
        begin
            model_mtimecmp = merge_bytes(model_mtimecmp, data, strb);
        end
    endtask

    task automatic read_check(input string test, input clint_pkg::offset_t offset);
        clint_pkg::data_t data;
        clint_pkg::resp_t resp;
        int hs_edge;
        axi_read(offset, data, resp, hs_edge);
        check_resp(test, `CLINT_RESP_OKAY, resp);
        if (offset == `CLINT_MTIME_OFFSET)
        begin
            check_data(test, mtime_before(hs_edge), data);
        end
        else
        begin
            check_data(test, model_mtimecmp, data);
        end
    endtask

    task automatic test_reset_irq();
        check_bit("reset", 1'b0, axi_awready);
        check_bit("reset", 1'b0, axi_wready);
        check_bit("reset", 1'b0, axi_arready);
        check_bit("reset", 1'b0, axi_bvalid);
        check_bit("reset", 1'b0, axi_rvalid);
        check_bit("reset", 1'b0, timer_irq);
        repeat (10) @(negedge clk);
        check_irq("reset", 1, irq_count);
        read_check("reset", `CLINT_MTIMECMP_OFFSET);
    endtask

    task automatic test_mtime_count();
        write_reg("mtime_count", `CLINT_MTIME_OFFSET, take_bits(64), 8'hff);
        repeat (int'(take_bits(4))) @(negedge clk);
        read_check("mtime_count", `CLINT_MTIME_OFFSET);
    endtask

    task automatic test_strobes();
        clint_pkg::data_t data;
        clint_pkg::strb_t strb;
        write_reg("strobes", `CLINT_MTIMECMP_OFFSET, take_bits(64), 8'hff);
        data = take_bits(64);
        strb = clint_pkg::strb_t'(take_bits(8));
        write_reg("strobes", `CLINT_MTIMECMP_OFFSET, data, strb);
        read_check("strobes", `CLINT_MTIMECMP_OFFSET);
        write_reg("strobes", `CLINT_MTIME_OFFSET, take_bits(64), 8'hff);
        data = take_bits(64);
        strb = clint_pkg::strb_t'(take_bits(8));
        write_reg("strobes", `CLINT_MTIME_OFFSET, data, strb);
        read_check("strobes", `CLINT_MTIME_OFFSET);
    endtask

    task automatic test_irq_timing();
        clint_pkg::data_t start;
        int target;
        write_reg("irq_timing", `CLINT_MTIMECMP_OFFSET, '1, 8'hff);
        irq_count = 0;
        // 48 bits keep start plus 40 clear of wrap-around
        start = take_bits(48);
        write_reg("irq_timing", `CLINT_MTIME_OFFSET, start, 8'hff);
        write_reg("irq_timing", `CLINT_MTIMECMP_OFFSET, start + 64'd40, 8'hff);
        // edge after which the model's mtime equals mtimecmp
        target = model_mtime_edge + int'(model_mtimecmp - model_mtime_base);
        while (cycle_count < target)
        begin
            @(negedge clk);
        end
        check_irq("irq_timing", 0, irq_count);
        repeat (3) @(negedge clk);
        check_irq("irq_timing", 1, irq_count);
        repeat (50) @(negedge clk);
        check_irq("irq_timing", 1, irq_count);
    endtask

    task automatic test_unmapped();
        clint_pkg::data_t data;
        clint_pkg::resp_t resp;
        int hs_edge;
        axi_write(UNMAPPED_OFFSET, take_bits(64), 8'hff, resp, hs_edge);
        check_resp("unmapped", `CLINT_RESP_SLVERR, resp);
        axi_read(UNMAPPED_OFFSET, data, resp, hs_edge);
        check_resp("unmapped", `CLINT_RESP_SLVERR, resp);
        check_data("unmapped", '0, data);
        read_check("unmapped", `CLINT_MTIMECMP_OFFSET);
        read_check("unmapped", `CLINT_MTIME_OFFSET);
    endtask

    task automatic test_back_pressure();
        clint_pkg::data_t first;
        clint_pkg::data_t second;
        clint_pkg::data_t held_data;
        clint_pkg::resp_t held_rresp;
        clint_pkg::resp_t held_bresp;
        clint_pkg::data_t data;
        clint_pkg::resp_t resp;
        int w_edge;
        int r_edge;
        first = take_bits(64);
        second = take_bits(64);
        offer_write(`CLINT_MTIMECMP_OFFSET, first, 8'hff);
        finish_write_handshake(w_edge);
        model_mtimecmp = first;
        offer_read(`CLINT_MTIME_OFFSET);
        finish_read_handshake(r_edge);
        check_data("back_pressure", mtime_before(r_edge), axi_rdata);
        held_data = axi_rdata;
        held_rresp = axi_rresp;
        held_bresp = axi_bresp;
        // second write waits behind the pending B beat
        offer_write(`CLINT_MTIMECMP_OFFSET, second, 8'hff);
        repeat (8)
        begin
            @(negedge clk);
            check_bit("back_pressure", 1'b1, axi_bvalid);
            check_bit("back_pressure", 1'b1, axi_rvalid);
            check_bit("back_pressure", 1'b0, axi_awready);
            check_bit("back_pressure", 1'b0, axi_wready);
            check_data("back_pressure", held_data, axi_rdata);
            check_resp("back_pressure", held_rresp, axi_rresp);
            check_resp("back_pressure", held_bresp, axi_bresp);
        end
        check_resp("back_pressure", `CLINT_RESP_OKAY, held_bresp);
        check_resp("back_pressure", `CLINT_RESP_OKAY, held_rresp);
        collect_read_response(0, data, resp);
        check_data("back_pressure", held_data, data);
        check_resp("back_pressure", `CLINT_RESP_OKAY, resp);
        collect_write_response(0, resp);
        check_resp("back_pressure", `CLINT_RESP_OKAY, resp);
        finish_write_handshake(w_edge);
        collect_write_response(int'(take_bits(2)), resp);
        check_resp("back_pressure", `CLINT_RESP_OKAY, resp);
        model_mtimecmp = second;
        read_check("back_pressure", `CLINT_MTIMECMP_OFFSET);
    endtask

    initial
    begin
        lfsr_state = LFSR_SEED;
        rst_n = 1'b0;
        idle_bus();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        model_mtime_base = '0;
        model_mtime_edge = cycle_count;
        model_mtimecmp = MTIMECMP_AFTER_RESET;
        test_reset_irq();
        test_mtime_count();
        test_strobes();
        test_irq_timing();
        test_unmapped();
        test_back_pressure();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/clint_pkg.sv
source/clint_axi_slave.sv
source/clint_timer.sv
source/clint.sv
testbench/clint_properties.sv
testbench/clint_tb.sv

/* Makefile */
VERILATOR  := verilator
TOP        := clint_tb
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall --timescale 1ns/100ps
PASS_TEXT  := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
